/* verilog/dcache_pkg.sv */
// data cache shared definitions
`default_nettype none

package dcache_pkg;

  // geometry
  localparam int ADDR_W   = 32;
  localparam int WORD_W   = 64;
  localparam int STRB_W   = WORD_W / 8;
  localparam int OFFSET_W = 4;  // 16-byte line
  localparam int LINE_W   = 128;
  localparam int WAYS     = 2;

  // burst shape toward memory
  localparam int BEATS  = LINE_W / WORD_W;
  localparam int BEAT_W = $clog2(BEATS);

  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [WORD_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } core_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] rdata;  // reads only
  } core_rsp_t;

  // one burst order with a line-aligned addr
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    line_t             line;
  } mem_cmd_t;

endpackage

`default_nettype wire

/* verilog/dcache_core_port.sv */
// core request and response holder
`timescale 1ns/10ps
`default_nettype none

module dcache_core_port (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  dcache_pkg::core_req_t req_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output dcache_pkg::core_rsp_t rsp_o,
  output logic                  held_o,
  output dcache_pkg::core_req_t held_req_o,
  input  logic                  done_i,
  input  dcache_pkg::core_rsp_t done_rsp_i
);
  import dcache_pkg::*;

  logic      full_q;  // request held or response pending
  logic      rsp_valid_q;
  core_req_t req_q;
  core_rsp_t rsp_q;

  assign req_ready_o = !full_q;
  assign held_o      = full_q && !rsp_valid_q;
  assign held_req_o  = req_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_valid_i && !full_q) full_q <= 1'b1;
      if (done_i) rsp_valid_q <= 1'b1;
      if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
        full_q      <= 1'b0;  // reopens next cycle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && !full_q) req_q <= req_i;
    if (done_i) rsp_q <= done_rsp_i;
  end

endmodule

`default_nettype wire

/* verilog/dcache_tag_store.sv */
// tag, valid and dirty store
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_store #(
  parameter int INDEX_W = 6
) (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  logic [INDEX_W-1:0]                                       index_i,
  input  logic [dcache_pkg::ADDR_W-INDEX_W-dcache_pkg::OFFSET_W-1:0] tag_i,
  output logic                                                     hit_o,
  output logic                                                     hit_way_o,
  output logic                                                     victim_way_o,
  output logic                                                     victim_dirty_o,
  output logic [dcache_pkg::ADDR_W-INDEX_W-dcache_pkg::OFFSET_W-1:0] victim_tag_o,
  input  logic                                                     fill_i,
  input  logic                                                     fill_way_i,
  input  logic                                                     mark_dirty_i,
  input  logic                                                     dirty_way_i
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  localparam int SETS  = 2 ** INDEX_W;

  logic [TAG_W-1:0] tag_q   [WAYS][SETS];
  logic [SETS-1:0]  valid_q [WAYS];
  logic [SETS-1:0]  dirty_q [WAYS];
  logic [WAYS-1:0]  way_hit;
  logic             victim_q;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[w][index_i] && (tag_q[w][index_i] == tag_i);
    end
  end

  assign hit_o          = |way_hit;
  assign hit_way_o      = way_hit[1];  // way 1 or else way 0
  assign victim_way_o   = victim_q;
  assign victim_dirty_o = valid_q[victim_q][index_i] && dirty_q[victim_q][index_i];
  assign victim_tag_o   = tag_q[victim_q][index_i];

  always_ff @(posedge clk) begin
    if (fill_i) tag_q[fill_way_i][index_i] <= tag_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      victim_q <= 1'b0;
    end else begin
      victim_q <= !victim_q;  // free-running replacement toggle
      if (fill_i) begin
        valid_q[fill_way_i][index_i] <= 1'b1;
        dirty_q[fill_way_i][index_i] <= 1'b0;
      end
      if (mark_dirty_i) dirty_q[dirty_way_i][index_i] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_data_store.sv */
// line storage for both ways
`timescale 1ns/10ps
`default_nettype none

module dcache_data_store #(
  parameter int INDEX_W = 6
) (
  input  logic                              clk,
  input  logic [INDEX_W-1:0]                index_i,
  output dcache_pkg::line_t                 rd_line_o [dcache_pkg::WAYS],
  input  logic                              wr_en_i,
  input  logic                              wr_way_i,
  input  dcache_pkg::line_t                 wr_line_i,
  input  logic [dcache_pkg::LINE_W/8-1:0]   wr_byte_en_i
);
  import dcache_pkg::*;

  localparam int SETS = 2 ** INDEX_W;

  line_t mem_q [WAYS][SETS];
  line_t rd_q  [WAYS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < LINE_W / 8; b++) begin
        if (wr_byte_en_i[b]) mem_q[wr_way_i][index_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
      end
    end
    for (int w = 0; w < WAYS; w++) begin
      rd_q[w] <= mem_q[w][index_i];  // old data on same-cycle write
    end
  end

  assign rd_line_o = rd_q;

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
// cache control FSM
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl #(
  parameter int INDEX_W = 6
) (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  logic                                                     held_i,
  input  dcache_pkg::core_req_t                                    held_req_i,
  output logic                                                     done_o,
  output dcache_pkg::core_rsp_t                                    done_rsp_o,
  output logic [INDEX_W-1:0]                                       index_o,
  output logic [dcache_pkg::ADDR_W-INDEX_W-dcache_pkg::OFFSET_W-1:0] tag_o,
  input  logic                                                     hit_i,
  input  logic                                                     hit_way_i,
  input  logic                                                     victim_way_i,
  input  logic                                                     victim_dirty_i,
  input  logic [dcache_pkg::ADDR_W-INDEX_W-dcache_pkg::OFFSET_W-1:0] victim_tag_i,
  output logic                                                     fill_o,
  output logic                                                     fill_way_o,
  output logic                                                     mark_dirty_o,
  output logic                                                     dirty_way_o,
  input  dcache_pkg::line_t                                        rd_line_i [dcache_pkg::WAYS],
  output logic                                                     wr_en_o,
  output logic                                                     wr_way_o,
  output dcache_pkg::line_t                                        wr_line_o,
  output logic [dcache_pkg::LINE_W/8-1:0]                          wr_byte_en_o,
  output logic                                                     cmd_valid_o,
  input  logic                                                     cmd_ready_i,
  output dcache_pkg::mem_cmd_t                                     cmd_o,
  input  logic                                                     mem_done_i,
  input  dcache_pkg::line_t                                        fill_line_i
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_RESPOND, S_EVICT, S_REFILL, S_REPLAY
  } state_t;

  state_t            state_q;
  logic              vway_q;  // victim latched at miss
  logic              cmd_valid_q;
  mem_cmd_t          cmd_q;
  line_t             hit_line;
  logic              hi_word;
  logic [ADDR_W-1:0] line_addr;

  assign index_o   = held_req_i.addr[OFFSET_W +: INDEX_W];
  assign tag_o     = held_req_i.addr[ADDR_W-1 -: TAG_W];
  assign hi_word   = held_req_i.addr[3];
  assign line_addr = {held_req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign hit_line  = rd_line_i[hit_way_i];

  assign done_o           = (state_q == S_LOOKUP) && hit_i;
  assign done_rsp_o.rdata = hit_line[hi_word*WORD_W +: WORD_W];

  // write hit places the word into its half of the line
  assign mark_dirty_o = done_o && held_req_i.write;
  assign dirty_way_o  = hit_way_i;
  assign fill_o       = (state_q == S_REFILL) && mem_done_i;
  assign fill_way_o   = vway_q;

  assign wr_en_o      = mark_dirty_o || fill_o;
  assign wr_way_o     = fill_o ? vway_q : hit_way_i;
  assign wr_line_o    = fill_o ? fill_line_i : {BEATS{held_req_i.wdata}};
  assign wr_byte_en_o = fill_o  ? '1 :
                        hi_word ? {held_req_i.wstrb, {STRB_W{1'b0}}} :
                                  {{STRB_W{1'b0}}, held_req_i.wstrb};

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      cmd_valid_q <= 1'b0;
    end else begin
      if (cmd_valid_q && cmd_ready_i) cmd_valid_q <= 1'b0;
      case (state_q)
        S_IDLE:    if (held_i) state_q <= S_LOOKUP;
        S_LOOKUP: begin
          if (hit_i) begin
            state_q <= S_RESPOND;
          end else begin
            cmd_valid_q <= 1'b1;
            state_q     <= victim_dirty_i ? S_EVICT : S_REFILL;
          end
        end
        S_RESPOND: state_q <= S_IDLE;  // response now held by the core port
        S_EVICT: begin
          if (mem_done_i) begin
            cmd_valid_q <= 1'b1;  // now the refill
            state_q     <= S_REFILL;
          end
        end
        S_REFILL:  if (mem_done_i) state_q <= S_REPLAY;
        S_REPLAY:  state_q <= S_LOOKUP;  // data store read settles
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_LOOKUP && !hit_i) begin
      vway_q      <= victim_way_i;
      cmd_q.write <= victim_dirty_i;
      cmd_q.line  <= rd_line_i[victim_way_i];
      cmd_q.addr  <= victim_dirty_i ? {victim_tag_i, index_o, {OFFSET_W{1'b0}}} : line_addr;
    end else if (state_q == S_EVICT && mem_done_i) begin
      cmd_q.write <= 1'b0;
      cmd_q.addr  <= line_addr;
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_mem_port.sv */
// memory burst engine
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_port (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cmd_valid_i,
  output logic                            cmd_ready_o,
  input  dcache_pkg::mem_cmd_t            cmd_i,
  output logic                            done_o,
  output dcache_pkg::line_t               fill_line_o,
  output logic                            mem_req_valid_o,
  input  logic                            mem_req_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]   mem_req_addr_o,
  output logic                            mem_req_write_o,
  output logic                            mem_w_valid_o,
  input  logic                            mem_w_ready_i,
  output logic [dcache_pkg::WORD_W-1:0]   mem_w_data_o,
  input  logic                            mem_r_valid_i,
  output logic                            mem_r_ready_o,
  input  logic [dcache_pkg::WORD_W-1:0]   mem_r_data_i
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_REQ, M_WRITE, M_READ} mstate_t;

  mstate_t           state_q;
  mem_cmd_t          cmd_q;
  logic [BEAT_W-1:0] beat_q;
  line_t             fill_q;
  logic              done_q;
  logic              beat_xfer;

  assign cmd_ready_o     = (state_q == M_IDLE);
  assign mem_req_valid_o = (state_q == M_REQ);
  assign mem_req_addr_o  = cmd_q.addr;
  assign mem_req_write_o = cmd_q.write;
  assign mem_w_valid_o   = (state_q == M_WRITE);
  assign mem_w_data_o    = cmd_q.line[beat_q*WORD_W +: WORD_W];  // low word first
  assign mem_r_ready_o   = (state_q == M_READ);
  assign done_o          = done_q;
  assign fill_line_o     = fill_q;

  assign beat_xfer = (mem_w_valid_o && mem_w_ready_i) || (mem_r_ready_o && mem_r_valid_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= M_IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        M_IDLE: if (cmd_valid_i) state_q <= M_REQ;
        M_REQ: begin
          if (mem_req_ready_i) begin
            beat_q  <= '0;
            state_q <= cmd_q.write ? M_WRITE : M_READ;
          end
        end
        default: begin
          if (beat_xfer) begin
            if (beat_q == BEAT_W'(BEATS - 1)) begin
              done_q  <= 1'b1;
              state_q <= M_IDLE;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid_i && cmd_ready_o) cmd_q <= cmd_i;
    if (mem_r_ready_o && mem_r_valid_i) fill_q[beat_q*WORD_W +: WORD_W] <= mem_r_data_i;
  end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
// two-way write-back data cache
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
  parameter int INDEX_W = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  dcache_pkg::core_req_t         req_i,
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output dcache_pkg::core_rsp_t         rsp_o,
  output logic                          mem_req_valid_o,
  input  logic                          mem_req_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0] mem_req_addr_o,
  output logic                          mem_req_write_o,
  output logic                          mem_w_valid_o,
  input  logic                          mem_w_ready_i,
  output logic [dcache_pkg::WORD_W-1:0] mem_w_data_o,
  input  logic                          mem_r_valid_i,
  output logic                          mem_r_ready_o,
  input  logic [dcache_pkg::WORD_W-1:0] mem_r_data_i
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  logic               held;
  core_req_t          held_req;
  logic               done;
  core_rsp_t          done_rsp;
  logic [INDEX_W-1:0] index;
  logic [TAG_W-1:0]   tag;
  logic               hit;
  logic               hit_way;
  logic               victim_way;
  logic               victim_dirty;
  logic [TAG_W-1:0]   victim_tag;
  logic               fill;
  logic               fill_way;
  logic               mark_dirty;
  logic               dirty_way;
  line_t              rd_line [WAYS];
  logic               wr_en;
  logic               wr_way;
  line_t              wr_line;
  logic [LINE_W/8-1:0] wr_byte_en;
  logic               cmd_valid;
  logic               cmd_ready;
  mem_cmd_t           cmd;
  logic               mem_done;
  line_t              fill_line;

  dcache_core_port u_core_port (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
    .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
    .held_o(held), .held_req_o(held_req),
    .done_i(done), .done_rsp_i(done_rsp)
  );

  dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
    .clk(clk), .rst(rst),
    .held_i(held), .held_req_i(held_req),
    .done_o(done), .done_rsp_o(done_rsp),
    .index_o(index), .tag_o(tag),
    .hit_i(hit), .hit_way_i(hit_way),
    .victim_way_i(victim_way), .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
    .fill_o(fill), .fill_way_o(fill_way),
    .mark_dirty_o(mark_dirty), .dirty_way_o(dirty_way),
    .rd_line_i(rd_line),
    .wr_en_o(wr_en), .wr_way_o(wr_way), .wr_line_o(wr_line), .wr_byte_en_o(wr_byte_en),
    .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready), .cmd_o(cmd),
    .mem_done_i(mem_done), .fill_line_i(fill_line)
  );

  dcache_tag_store #(.INDEX_W(INDEX_W)) u_tag_store (
    .clk(clk), .rst(rst),
    .index_i(index), .tag_i(tag),
    .hit_o(hit), .hit_way_o(hit_way),
    .victim_way_o(victim_way), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag),
    .fill_i(fill), .fill_way_i(fill_way),
    .mark_dirty_i(mark_dirty), .dirty_way_i(dirty_way)
  );

  dcache_data_store #(.INDEX_W(INDEX_W)) u_data_store (
    .clk(clk),
    .index_i(index), .rd_line_o(rd_line),
    .wr_en_i(wr_en), .wr_way_i(wr_way), .wr_line_i(wr_line), .wr_byte_en_i(wr_byte_en)
  );

  dcache_mem_port u_mem_port (
    .clk(clk), .rst(rst),
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_i(cmd),
    .done_o(mem_done), .fill_line_o(fill_line),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
    .mem_req_addr_o(mem_req_addr_o), .mem_req_write_o(mem_req_write_o),
    .mem_w_valid_o(mem_w_valid_o), .mem_w_ready_i(mem_w_ready_i), .mem_w_data_o(mem_w_data_o),
    .mem_r_valid_i(mem_r_valid_i), .mem_r_ready_o(mem_r_ready_o), .mem_r_data_i(mem_r_data_i)
  );

endmodule

`default_nettype wire

/* verification/dcache_properties.sv */
// cache handshake assertions
`timescale 1ns/10ps
`default_nettype none

module dcache_properties (
  input logic                  clk,
  input logic                  rst,
  input logic                  req_ready_i,
  input logic                  rsp_valid_i,
  input logic                  rsp_ready_i,
  input dcache_pkg::core_rsp_t rsp_i,
  input logic                  mem_req_valid_i,
  input logic                  mem_req_ready_i
);
  import dcache_pkg::*;

  int fail_cnt = 0;  // read back by the testbench

  // waiting response keeps its word
  rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      $error("response changed or dropped while waiting");
      fail_cnt++;
    end

  mem_req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i)
    else begin
      $error("memory request dropped before ready");
      fail_cnt++;
    end

  no_accept_while_rsp: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_i |-> !req_ready_i)
    else begin
      $error("request port open while a response waits");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
// data cache testbench
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam int N_ACCESS = 4 + 2 + 6 + 300;
  localparam int LIMIT    = 60 * N_ACCESS + 10;

  typedef struct {
    bit        is_read;
    bit        lat_chk;
    core_rsp_t exp;
    int        acc;
  } exp_t;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              req_valid_i;
  logic              req_ready_o;
  core_req_t         req_i;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  core_rsp_t         rsp_o;
  logic              mem_req_valid_o;
  logic              mem_req_ready_i;
  logic [ADDR_W-1:0] mem_req_addr_o;
  logic              mem_req_write_o;
  logic              mem_w_valid_o;
  logic              mem_w_ready_i;
  logic [WORD_W-1:0] mem_w_data_o;
  logic              mem_r_valid_i;
  logic              mem_r_ready_o;
  logic [WORD_W-1:0] mem_r_data_i;

  logic [WORD_W-1:0] mem [4096];      // main memory model
  logic [WORD_W-1:0] ref_mem [4096];  // core's view
  exp_t              exp_q [$];
  int                cycle = 0;
  int                errors = 0;
  int                n_tests = 0;
  int                n_failed = 0;
  int                err_start;
  string             test_name = "reset";
  bit                bp_en = 1'b0;
  logic [31:0]       rng_q = 32'hf9d9;
  logic [31:0]       stim_q = 32'hf9d9;

  // memory model state
  logic              req_x;
  logic              req_wr;
  logic              w_x;
  logic              r_x;
  logic              busy_rd;
  logic              busy_wr;
  logic [ADDR_W-1:0] req_addr;
  logic [WORD_W-1:0] w_data;
  logic [11:0]       base;
  logic [11:0]       beat;
  int                rsp_first;
  bit                rsp_seen = 1'b0;

  dcache_top #(.INDEX_W(6)) dut (.*);

  bind dcache_top dcache_properties u_props (
    .clk(clk), .rst(rst), .req_ready_i(req_ready_o),
    .rsp_valid_i(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_i(rsp_o),
    .mem_req_valid_i(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i)
  );

  always #5 clk = !clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory fill pattern from the whole word index
  function automatic logic [WORD_W-1:0] pattern(input logic [11:0] widx);
    return {32'hc0de0000 | {20'h0, widx}, ~{20'h0, widx} ^ 32'h5a5a5a5a};
  endfunction

  function automatic logic [WORD_W-1:0] merge_word(input logic [WORD_W-1:0] old,
                                                   input logic [WORD_W-1:0] wdata,
                                                   input logic [STRB_W-1:0] wstrb);
    logic [WORD_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (wstrb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_word(input string name, input core_rsp_t exp, input core_rsp_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp.rdata, act.rdata);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s latency expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // handshakes seen at negedge take effect on the next rising edge
  always @(negedge clk) begin
    req_x    = mem_req_valid_o && mem_req_ready_i;
    req_addr = mem_req_addr_o;
    req_wr   = mem_req_write_o;
    w_x      = mem_w_valid_o && mem_w_ready_i;
    w_data   = mem_w_data_o;
    r_x      = mem_r_valid_i && mem_r_ready_o;
  end

  always @(posedge clk) begin
    #1;
    if (!rst) begin
      if (req_x) begin
        base = req_addr[14:3];
        beat = 12'd0;
        busy_wr = req_wr;
        busy_rd = !req_wr;
      end
      if (w_x) begin
        mem[base + beat] = w_data;
        beat = beat + 12'd1;
        if (beat == 12'd2) busy_wr = 1'b0;
      end
      if (r_x) begin
        beat = beat + 12'd1;
        if (beat == 12'd2) busy_rd = 1'b0;
      end
    end
    rng_q = xorshift(rng_q);
    mem_req_ready_i = (rng_q[1:0] != 2'b00);
    mem_w_ready_i   = busy_wr && (rng_q[3:2] != 2'b00);
    if (!(mem_r_valid_i && !r_x)) mem_r_valid_i = busy_rd && (rng_q[5:4] != 2'b00);
    mem_r_data_i = mem[base + beat];
    rsp_ready_i  = bp_en ? rng_q[6] : 1'b1;
  end

  always @(negedge clk) begin
    exp_t e;
    if (!rst) begin
      if (rsp_valid_o && !rsp_seen) begin
        rsp_seen  = 1'b1;
        rsp_first = cycle;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_seen = 1'b0;
        if (exp_q.size() == 0) begin
          $display("response arrived with no request outstanding in %s", test_name);
          errors++;
        end else begin
          e = exp_q.pop_front();
          if (e.is_read) check_word(test_name, e.exp, rsp_o);
          if (e.lat_chk) check_latency(test_name, 2, rsp_first - e.acc);
        end
      end
    end
  end

  always @(posedge clk) begin
    if (cycle >= LIMIT) begin
      $display("timeout after %0d cycles in %s", cycle, test_name);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic access(input logic [31:0] addr, input logic wr, input logic [63:0] wdata,
                        input logic [7:0] wstrb, input bit lat_chk);
    exp_t        e;
    logic [11:0] widx;
    widx = addr[14:3];
    @(posedge clk);
    #1;
    req_valid_i = 1'b1;
    req_i.addr  = addr;
    req_i.write = wr;
    req_i.wdata = wdata;
    req_i.wstrb = wstrb;
    @(negedge clk);
    while (!req_ready_o) @(negedge clk);
    e.is_read = !wr;
    e.lat_chk = lat_chk;
    e.acc     = cycle + 1;  // value after the accepting edge
    if (wr) ref_mem[widx] = merge_word(ref_mem[widx], wdata, wstrb);
    e.exp.rdata = ref_mem[widx];
    exp_q.push_back(e);
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) @(negedge clk);
    n_tests++;
    if (errors == err_start) begin
      $display("test %s done, ok", test_name);
    end else begin
      $display("test %s done, %0d errors", test_name, errors - err_start);
      n_failed++;
    end
  endtask

  initial begin
    logic [3:0] line;
    req_valid_i = 1'b0;
    req_i = '0;
    rsp_ready_i = 1'b1;
    mem_req_ready_i = 1'b0;
    mem_w_ready_i = 1'b0;
    mem_r_valid_i = 1'b0;
    mem_r_data_i = '0;
    busy_rd = 1'b0;
    busy_wr = 1'b0;
    base = 12'd0;
    beat = 12'd0;
    for (int i = 0; i < 4096; i++) begin
      mem[i]     = pattern(12'(i));
      ref_mem[i] = pattern(12'(i));
    end
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;

    start_test("cold_read");
    access(32'h2000, 1'b0, '0, '0, 1'b0);
    access(32'h2008, 1'b0, '0, '0, 1'b0);
    access(32'h3458, 1'b0, '0, '0, 1'b0);
    access(32'h3450, 1'b0, '0, '0, 1'b0);
    end_test();

    start_test("strobe_merge");
    access(32'h1238, 1'b1, 64'h1122334455667788, 8'b0011_0101, 1'b0);
    access(32'h1238, 1'b0, '0, '0, 1'b1);  // hit with fixed latency
    end_test();

    start_test("same_set_evict");
    for (int i = 0; i < 3; i++) begin
      stim_q = xorshift(stim_q);
      access(32'h100 + 32'(i) * 32'h400, 1'b1, {stim_q, ~stim_q}, 8'hff, 1'b0);
    end
    for (int i = 0; i < 3; i++) access(32'h100 + 32'(i) * 32'h400, 1'b0, '0, '0, 1'b0);
    end_test();

    start_test("random_mix");
    bp_en = 1'b1;
    for (int i = 0; i < 300; i++) begin
      stim_q = xorshift(stim_q);
      line = stim_q[3:0];
      access({20'h0, line[3:2], 4'h0, line[1:0], stim_q[4], 3'b000}, stim_q[5],
             {stim_q, xorshift(stim_q)}, stim_q[15:8], 1'b0);
    end
    end_test();
    bp_en = 1'b0;

    errors = errors + dut.u_props.fail_cnt;
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/dcache_pkg.sv
verilog/dcache_core_port.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_mem_port.sv
verilog/dcache_top.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
verilator --binary --timing --assert -f src.f --top-module dcache_tb \
  --Mdir obj_dir -o sim_dcache > build.log 2>&1 \
  && ./obj_dir/sim_dcache > sim.log 2>&1 \
  ; grep -q "All tests passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }
